// ==== hdl/ingress_buffer_cfg_pkg.sv ====
package ingress_buffer_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Port and word geometry

	localparam int num_ports = 4;
	localparam int port_bits = $clog2(num_ports);
	localparam int word_bits = 32;

	// Each port owns one ring of this many words in the packet RAM
	localparam int region_words = 64;
	localparam int ptr_bits = $clog2(region_words);
	localparam int addr_bits = port_bits + ptr_bits;

	// Frame length in whole words, 1 up to max_frame_words
	localparam int max_frame_words = 16;
	localparam int len_bits = $clog2(max_frame_words + 1);

	// Queue depths
	localparam int stage_depth = 32;
	localparam int meta_depth = 4;
	localparam int out_depth = 4;

endpackage

// ==== hdl/ingress_buffer_types_pkg.sv ====
package ingress_buffer_types_pkg;
	import ingress_buffer_cfg_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Data and pointers

	typedef logic [word_bits-1:0] word_t;

	// Ring offset with the extra wrap bit on top
	typedef logic [ptr_bits:0] ring_ptr_t;

	// Port field selects the region, offset selects the word in it
	typedef struct packed {
		logic [port_bits-1:0] port;
		logic [ptr_bits-1:0] offset;
	} ram_addr_t;

	//////////////////////////////////////////////////////////////////////
	// Bus payloads

	// Ingress beat
	typedef struct packed {
		word_t data;
		logic last;
	} rx_beat_t;

	// One packet RAM write
	typedef struct packed {
		logic en;
		ram_addr_t addr;
		word_t data;
	} ram_wr_t;

	// Per-frame record, length only
	typedef struct packed {
		logic [len_bits-1:0] len;
	} frame_meta_t;

	// Fabric beat, tagged with the source port
	typedef struct packed {
		word_t data;
		logic last;
		logic [port_bits-1:0] port;
	} out_beat_t;

endpackage

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 4
) (
	input logic clk_ram_ctl,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic full,
	output logic [$clog2(depth+1)-1:0] count
);

	// Storage array
	payload_t mem [depth];

	logic [$clog2(depth)-1:0] wr_idx;
	logic [$clog2(depth)-1:0] rd_idx;

	//////////////////////////////////////////////////////////////////////
	// Indices and occupancy

	always_ff @(posedge clk_ram_ctl or negedge rst_n) begin
		if (!rst_n) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_idx <= (wr_idx == depth - 1) ? '0 : wr_idx + 1'b1;
			if (pop)
				rd_idx <= (rd_idx == depth - 1) ? '0 : rd_idx + 1'b1;
			// Count moves only when one side is active
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_ram_ctl) begin
		if (push)
			mem[wr_idx] <= push_data;
	end

	// Head word shows without a pop
	assign pop_data = mem[rd_idx];
	assign empty = (count == 0);
	assign full = (count == depth);

	// Callers must respect the flags
	a_no_overflow: assert property (@(posedge clk_ram_ctl) disable iff (!rst_n)
		!(push && full));
	a_no_underflow: assert property (@(posedge clk_ram_ctl) disable iff (!rst_n)
		!(pop && empty));

endmodule

// ==== hdl/ingress_port.sv ====
`timescale 1ns/100ps

module ingress_port
	import ingress_buffer_cfg_pkg::*;
	import ingress_buffer_types_pkg::*;
#(
	parameter logic [port_bits-1:0] port_id = '0
) (
	input logic clk_ram_ctl,
	input logic rst_n,
	input logic rx_valid,
	input rx_beat_t rx_beat,
	output logic rx_ready,
	input logic grant,
	output logic wr_req,
	output ram_wr_t ram_wr,
	input ring_ptr_t rd_ptr,
	input logic meta_pop,
	output logic meta_valid,
	output frame_meta_t meta
);

	logic rx_fire;
	logic [len_bits-1:0] rx_cnt;
	rx_beat_t stg_head;
	logic stg_full;
	frame_meta_t len_in;
	frame_meta_t len_head;
	logic len_empty;
	logic len_full;
	logic meta_empty;
	logic meta_full;
	logic frame_done;
	ring_ptr_t wr_ptr;
	ring_ptr_t used_words;
	ring_ptr_t free_words;
	logic ring_full;
	logic frame_ready;

	//////////////////////////////////////////////////////////////////////
	// Frame staging

	assign rx_ready = !stg_full && !len_full;
	assign rx_fire = rx_valid && rx_ready;

	// Word count of the frame now arriving
	always_ff @(posedge clk_ram_ctl or negedge rst_n) begin
		if (!rst_n)
			rx_cnt <= '0;
		else if (rx_fire)
			rx_cnt <= rx_beat.last ? '0 : rx_cnt + 1'b1;
	end

	assign len_in.len = rx_cnt + 1'b1;

	sync_fifo #(.payload_t(rx_beat_t), .depth(stage_depth)) stage_fifo_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst_n(rst_n),
		.push(rx_fire),
		.push_data(rx_beat),
		.pop(grant),
		.pop_data(stg_head),
		.empty(),
		.full(stg_full),
		.count()
	);

	// One entry per fully staged frame
	sync_fifo #(.payload_t(frame_meta_t), .depth(stage_depth)) len_fifo_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst_n(rst_n),
		.push(rx_fire && rx_beat.last),
		.push_data(len_in),
		.pop(frame_done),
		.pop_data(len_head),
		.empty(len_empty),
		.full(len_full),
		.count()
	);

	//////////////////////////////////////////////////////////////////////
	// Ring space and write request

	// Wrap bit makes the difference exact, 0 up to region_words
	assign used_words = wr_ptr - rd_ptr;
	assign free_words = ring_ptr_t'(region_words) - used_words;
	assign ring_full = (wr_ptr[ptr_bits-1:0] == rd_ptr[ptr_bits-1:0]) &&
		(wr_ptr[ptr_bits] != rd_ptr[ptr_bits]);

	assign frame_ready = !len_empty && !meta_full &&
		(free_words >= ring_ptr_t'(len_head.len));

	// Request drops with the last word of the granted frame
	assign wr_req = grant ? !stg_head.last : frame_ready;
	assign frame_done = grant && stg_head.last;

	// Granted port streams one staged word per cycle
	assign ram_wr.en = grant;
	assign ram_wr.addr.port = port_id;
	assign ram_wr.addr.offset = wr_ptr[ptr_bits-1:0];
	assign ram_wr.data = stg_head.data;

	always_ff @(posedge clk_ram_ctl or negedge rst_n) begin
		if (!rst_n)
			wr_ptr <= '0;
		else if (grant)
			wr_ptr <= wr_ptr + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Frames written to RAM and ready for readout

	sync_fifo #(.payload_t(frame_meta_t), .depth(meta_depth)) meta_fifo_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst_n(rst_n),
		.push(frame_done),
		.push_data(len_head),
		.pop(meta_pop),
		.pop_data(meta),
		.empty(meta_empty),
		.full(meta_full),
		.count()
	);

	assign meta_valid = !meta_empty;

	// Free-space check against the readout pointer keeps unread words safe
	a_no_write_full: assert property (@(posedge clk_ram_ctl) disable iff (!rst_n)
		ram_wr.en |-> !ring_full);

endmodule

// ==== hdl/write_arbiter.sv ====
`timescale 1ns/100ps

module write_arbiter
	import ingress_buffer_cfg_pkg::*;
	import ingress_buffer_types_pkg::*;
(
	input logic clk_ram_ctl,
	input logic rst_n,
	input logic [num_ports-1:0] wr_req,
	output logic [num_ports-1:0] grant,
	input ram_wr_t port_wr [num_ports],
	output ram_wr_t ram_wr
);

	logic busy;
	logic [port_bits-1:0] rr_ptr;
	logic [port_bits-1:0] win_port;
	logic win_valid;

	// Nearest requester at or after rr_ptr wins
	always_comb begin
		win_valid = 1'b0;
		win_port = '0;
		for (int k = num_ports - 1; k >= 0; k--) begin
			if (wr_req[(int'(rr_ptr) + k) % num_ports]) begin
				win_valid = 1'b1;
				win_port = port_bits'((int'(rr_ptr) + k) % num_ports);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame-granular grant

	always_ff @(posedge clk_ram_ctl or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			grant <= '0;
			rr_ptr <= '0;
		end else if (busy) begin
			// Owner dropped its request on the last word
			if (!(|(grant & wr_req))) begin
				busy <= 1'b0;
				grant <= '0;
			end
		end else if (win_valid) begin
			busy <= 1'b1;
			grant <= num_ports'(1) << win_port;
			rr_ptr <= port_bits'((int'(win_port) + 1) % num_ports);
		end
	end

	// Only the granted write reaches the RAM
	always_comb begin
		ram_wr = '0;
		for (int i = 0; i < num_ports; i++) begin
			if (grant[i])
				ram_wr = ram_wr_t'(ram_wr | port_wr[i]);
		end
	end

	// A waiting request stays up until its grant arrives
	for (genvar g = 0; g < num_ports; g++) begin : req_chk
		a_req_held: assert property (@(posedge clk_ram_ctl) disable iff (!rst_n)
			wr_req[g] && !grant[g] |=> wr_req[g] || grant[g]);
	end

endmodule

// ==== hdl/packet_ram.sv ====
`timescale 1ns/100ps

module packet_ram
	import ingress_buffer_cfg_pkg::*;
	import ingress_buffer_types_pkg::*;
(
	input logic clk_ram_ctl,
	input ram_wr_t ram_wr,
	input logic rd_en,
	input ram_addr_t rd_addr,
	output word_t rd_data
);

	// One ring region per port, port field on top
	word_t mem [num_ports * region_words];

	logic [addr_bits-1:0] wr_index;
	logic [addr_bits-1:0] rd_index;

	assign wr_index = ram_wr.addr;
	assign rd_index = rd_addr;

	// Registered read, one cycle after rd_en
	always_ff @(posedge clk_ram_ctl) begin
		if (ram_wr.en)
			mem[wr_index] <= ram_wr.data;
		if (rd_en)
			rd_data <= mem[rd_index];
	end

endmodule

// ==== hdl/frame_readout.sv ====
`timescale 1ns/100ps

module frame_readout
	import ingress_buffer_cfg_pkg::*;
	import ingress_buffer_types_pkg::*;
(
	input logic clk_ram_ctl,
	input logic rst_n,
	input logic [num_ports-1:0] meta_valid,
	input frame_meta_t meta [num_ports],
	output logic [num_ports-1:0] meta_pop,
	output ring_ptr_t rd_ptr [num_ports],
	output logic rd_en,
	output ram_addr_t rd_addr,
	input word_t rd_data,
	output logic frame_valid,
	output out_beat_t frame_beat,
	input logic fabric_ready
);

	logic active;
	logic [port_bits-1:0] cur_port;
	logic [port_bits-1:0] rr_ptr;
	logic [port_bits-1:0] pick_port;
	logic pick_valid;
	logic [len_bits-1:0] words_left;
	ring_ptr_t rd_cur;
	logic issue_last;
	logic take;
	logic inflight;
	logic inflight_last;
	logic [port_bits-1:0] inflight_port;
	logic [$clog2(out_depth+1):0] credit_used;
	out_beat_t skid_in;
	logic skid_empty;
	logic skid_full;
	logic [$clog2(out_depth+1)-1:0] skid_count;

	//////////////////////////////////////////////////////////////////////
	// Port selection

	// Round robin over ports with a written frame
	always_comb begin
		pick_valid = 1'b0;
		pick_port = '0;
		for (int k = num_ports - 1; k >= 0; k--) begin
			if (meta_valid[(int'(rr_ptr) + k) % num_ports]) begin
				pick_valid = 1'b1;
				pick_port = port_bits'((int'(rr_ptr) + k) % num_ports);
			end
		end
	end

	// Skid words plus the read still in flight
	assign credit_used = {1'b0, skid_count} + {{$clog2(out_depth+1){1'b0}}, inflight};
	assign rd_en = active && (credit_used < out_depth);
	assign rd_addr.port = cur_port;
	assign rd_addr.offset = rd_cur[ptr_bits-1:0];
	assign issue_last = rd_en && (words_left == 1);

	// Next frame may load while the last read of this one issues
	assign take = pick_valid && (!active || issue_last);
	assign meta_pop = take ? (num_ports'(1) << pick_port) : '0;

	//////////////////////////////////////////////////////////////////////
	// Read issue and pointer release

	always_ff @(posedge clk_ram_ctl or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			cur_port <= '0;
			rr_ptr <= '0;
			words_left <= '0;
			rd_cur <= '0;
			inflight <= 1'b0;
			for (int i = 0; i < num_ports; i++)
				rd_ptr[i] <= '0;
		end else begin
			inflight <= rd_en;
			if (rd_en) begin
				words_left <= words_left - 1'b1;
				rd_cur <= rd_cur + 1'b1;
			end
			// Whole frame read, ring space goes back to the port
			if (issue_last) begin
				rd_ptr[cur_port] <= rd_cur + 1'b1;
				active <= 1'b0;
			end
			if (take) begin
				active <= 1'b1;
				cur_port <= pick_port;
				words_left <= meta[pick_port].len;
				rr_ptr <= port_bits'((int'(pick_port) + 1) % num_ports);
				// Same port back to back, release not yet visible
				if (issue_last && (pick_port == cur_port))
					rd_cur <= rd_cur + 1'b1;
				else
					rd_cur <= rd_ptr[pick_port];
			end
		end
	end

	// Tag for the word returning next cycle
	always_ff @(posedge clk_ram_ctl) begin
		inflight_last <= issue_last;
		inflight_port <= cur_port;
	end

	//////////////////////////////////////////////////////////////////////
	// Output skid FIFO

	assign skid_in.data = rd_data;
	assign skid_in.last = inflight_last;
	assign skid_in.port = inflight_port;

	sync_fifo #(.payload_t(out_beat_t), .depth(out_depth)) skid_fifo_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst_n(rst_n),
		.push(inflight),
		.push_data(skid_in),
		.pop(frame_valid && fabric_ready),
		.pop_data(frame_beat),
		.empty(skid_empty),
		.full(skid_full),
		.count(skid_count)
	);

	assign frame_valid = !skid_empty;

	// Credit check leaves room for every issued read
	a_skid_room: assert property (@(posedge clk_ram_ctl) disable iff (!rst_n)
		rd_en |=> !skid_full);

endmodule

// ==== hdl/ingress_buffer.sv ====
`timescale 1ns/100ps

module ingress_buffer
	import ingress_buffer_cfg_pkg::*;
	import ingress_buffer_types_pkg::*;
(
	input logic clk_ram_ctl,
	input logic rst_n,
	input logic rx_valid [num_ports],
	input rx_beat_t rx_beat [num_ports],
	output logic rx_ready [num_ports],
	output logic frame_valid,
	output out_beat_t frame_beat,
	input logic fabric_ready
);

	logic [num_ports-1:0] wr_req;
	logic [num_ports-1:0] grant;
	ram_wr_t port_wr [num_ports];
	ram_wr_t ram_wr;
	ring_ptr_t rd_ptr [num_ports];
	logic [num_ports-1:0] meta_valid;
	logic [num_ports-1:0] meta_pop;
	frame_meta_t meta [num_ports];
	logic rd_en;
	ram_addr_t rd_addr;
	word_t rd_data;

	//////////////////////////////////////////////////////////////////////
	// Ingress ports, one ring region each

	for (genvar g = 0; g < num_ports; g++) begin : ports
		ingress_port #(.port_id(port_bits'(g))) port_i (
			.clk_ram_ctl(clk_ram_ctl),
			.rst_n(rst_n),
			.rx_valid(rx_valid[g]),
			.rx_beat(rx_beat[g]),
			.rx_ready(rx_ready[g]),
			.grant(grant[g]),
			.wr_req(wr_req[g]),
			.ram_wr(port_wr[g]),
			.rd_ptr(rd_ptr[g]),
			.meta_pop(meta_pop[g]),
			.meta_valid(meta_valid[g]),
			.meta(meta[g])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Shared RAM with write arbiter and readout

	write_arbiter arb_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst_n(rst_n),
		.wr_req(wr_req),
		.grant(grant),
		.port_wr(port_wr),
		.ram_wr(ram_wr)
	);

	packet_ram ram_i (
		.clk_ram_ctl(clk_ram_ctl),
		.ram_wr(ram_wr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	frame_readout readout_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst_n(rst_n),
		.meta_valid(meta_valid),
		.meta(meta),
		.meta_pop(meta_pop),
		.rd_ptr(rd_ptr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.frame_valid(frame_valid),
		.frame_beat(frame_beat),
		.fabric_ready(fabric_ready)
	);

endmodule

// ==== test/ingress_model.svh ====
`ifndef INGRESS_MODEL_SVH
`define INGRESS_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Expected frames, one queue set per port

// Words of frames whose last beat was accepted, oldest first
word_t exp_words [num_ports][$];
int exp_lens [num_ports][$];

// Beats of the frame still arriving on each port
word_t pend_words [num_ports][$];

// Xorshift state
logic [31:0] rng_state;

function automatic logic [31:0] xorshift32();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// Uniform pick in lo up to hi
function automatic int rand_range(input int lo, input int hi);
	return lo + int'(xorshift32() % (hi - lo + 1));
endfunction

// Accepted beat, frame moves to the expected queue on last
function automatic void record_beat(input int port, input word_t data, input logic last);
	pend_words[port].push_back(data);
	if (last) begin
		exp_lens[port].push_back(pend_words[port].size());
		while (pend_words[port].size() > 0)
			exp_words[port].push_back(pend_words[port].pop_front());
	end
endfunction

function automatic logic model_empty();
	for (int p = 0; p < num_ports; p++) begin
		if (exp_lens[p].size() != 0 || pend_words[p].size() != 0)
			return 1'b0;
	end
	return 1'b1;
endfunction

`endif

// ==== test/tb_ingress_buffer.sv ====
`timescale 1ns/100ps

module tb_ingress_buffer
	import ingress_buffer_cfg_pkg::*;
	import ingress_buffer_types_pkg::*;
();

	logic clk_ram_ctl;
	logic rst_n;
	logic rx_valid [num_ports];
	rx_beat_t rx_beat [num_ports];
	logic rx_ready [num_ports];
	logic frame_valid;
	out_beat_t frame_beat;
	logic fabric_ready;

	// Per-port source state
	int frames_to_send [num_ports];
	int tx_len [num_ports];
	int tx_idx [num_ports];
	int words_sent [num_ports];
	logic rx_hold [num_ports];
	int gap_pct;
	int ready_pct;
	int len_min;

	// Output frame being received
	logic out_active;
	logic [port_bits-1:0] out_port;
	int out_len;
	int out_idx;
	int frames_out;
	logic held_valid;
	out_beat_t held_beat;

	int test_errors;
	int total_errors;
	int tests_run;
	int tests_failed;

	`include "ingress_model.svh"

	ingress_buffer dut_i (
		.clk_ram_ctl(clk_ram_ctl),
		.rst_n(rst_n),
		.rx_valid(rx_valid),
		.rx_beat(rx_beat),
		.rx_ready(rx_ready),
		.frame_valid(frame_valid),
		.frame_beat(frame_beat),
		.fabric_ready(fabric_ready)
	);

	initial begin
		clk_ram_ctl = 1'b0;
		forever #5 clk_ram_ctl = ~clk_ram_ctl;
	end

	//////////////////////////////////////////////////////////////////////
	// Output checking

	task automatic check_out_beat(input out_beat_t beat);
		int p;
		word_t exp;
		p = int'(beat.port);
		// First beat of a frame takes the head of that port's queue
		if (!out_active) begin
			assert (exp_lens[p].size() > 0) else begin
				$display("[ERROR] %0t: frame from port %0d with none expected", $time, p);
				test_errors++;
			end
			if (exp_lens[p].size() == 0)
				return;
			out_len = exp_lens[p].pop_front();
			out_idx = 0;
			out_port = beat.port;
			out_active = 1'b1;
		end
		assert (beat.port == out_port) else begin
			$display("[ERROR] %0t: port %0d beat inside a port %0d frame", $time, p, out_port);
			test_errors++;
		end
		exp = exp_words[out_port].pop_front();
		assert (beat.data === exp) else begin
			$display("[ERROR] %0t: port %0d word %0d is %h, expected %h",
				$time, out_port, out_idx, beat.data, exp);
			test_errors++;
		end
		assert (beat.last === (out_idx == out_len - 1)) else begin
			$display("[ERROR] %0t: port %0d word %0d has last %b, frame length %0d",
				$time, out_port, out_idx, beat.last, out_len);
			test_errors++;
		end
		out_idx++;
		if (out_idx == out_len) begin
			out_active = 1'b0;
			frames_out++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// One clock of stimulus, driven on the falling edge

	task automatic step_cycle();
		@(negedge clk_ram_ctl);
		// Beat held by back-pressure must not move
		if (held_valid) begin
			assert (frame_valid && frame_beat === held_beat) else begin
				$display("[ERROR] %0t: output beat changed while fabric_ready was low", $time);
				test_errors++;
			end
		end
		for (int p = 0; p < num_ports; p++) begin
			// A refused beat stays on the bus unchanged
			if (!rx_hold[p]) begin
				if (tx_len[p] == 0 && frames_to_send[p] > 0) begin
					tx_len[p] = rand_range(len_min, max_frame_words);
					tx_idx[p] = 0;
					frames_to_send[p]--;
				end
				rx_valid[p] = (tx_len[p] != 0) && (rand_range(0, 99) >= gap_pct);
				rx_beat[p].data = xorshift32();
				rx_beat[p].last = (tx_idx[p] == tx_len[p] - 1);
			end
			// rx_ready comes from registers only, so it holds until the next edge
			rx_hold[p] = rx_valid[p] && !rx_ready[p];
			if (rx_valid[p] && rx_ready[p]) begin
				record_beat(p, rx_beat[p].data, rx_beat[p].last);
				words_sent[p]++;
				tx_idx[p]++;
				if (rx_beat[p].last)
					tx_len[p] = 0;
			end
		end
		fabric_ready = (rand_range(0, 99) < ready_pct);
		if (frame_valid && fabric_ready)
			check_out_beat(frame_beat);
		held_valid = frame_valid && !fabric_ready;
		held_beat = frame_beat;
	endtask

	function automatic logic traffic_idle();
		for (int p = 0; p < num_ports; p++) begin
			if (frames_to_send[p] != 0 || tx_len[p] != 0)
				return 1'b0;
		end
		return model_empty() && !out_active;
	endfunction

	task automatic drain_all(input int limit);
		int n;
		n = 0;
		while (!traffic_idle() && n < limit) begin
			step_cycle();
			n++;
		end
		if (!traffic_idle()) begin
			$display("Timeout: frames still not delivered after %0d cycles", limit);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
			$display("PASS  %s", name);
		else begin
			$display("FAIL  %s (%0d errors)", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		tests_run++;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int n;
		int base_frames;
		int base_words [num_ports];
		rng_state = 32'h6b0e;
		rst_n = 1'b0;
		fabric_ready = 1'b0;
		for (int p = 0; p < num_ports; p++) begin
			rx_valid[p] = 1'b0;
			rx_beat[p] = '0;
			rx_hold[p] = 1'b0;
			frames_to_send[p] = 0;
			tx_len[p] = 0;
			tx_idx[p] = 0;
			words_sent[p] = 0;
		end
		gap_pct = 0;
		ready_pct = 100;
		len_min = 1;
		out_active = 1'b0;
		out_port = '0;
		out_len = 0;
		out_idx = 0;
		frames_out = 0;
		held_valid = 1'b0;
		held_beat = '0;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(negedge clk_ram_ctl);
		rst_n = 1'b1;

		// Idle outputs straight after reset
		@(negedge clk_ram_ctl);
		assert (frame_valid === 1'b0) else begin
			$display("[ERROR] %0t: frame_valid high after reset", $time);
			test_errors++;
		end
		for (int p = 0; p < num_ports; p++) begin
			assert (rx_ready[p] === 1'b1) else begin
				$display("[ERROR] %0t: rx_ready low on port %0d after reset", $time, p);
				test_errors++;
			end
		end
		finish_test("reset state");

		// One frame per port, one port at a time
		base_frames = frames_out;
		for (int p = 0; p < num_ports; p++) begin
			frames_to_send[p] = 1;
			drain_all(500);
		end
		assert (frames_out - base_frames == num_ports) else begin
			$display("[ERROR] %0t: %0d frames delivered, expected %0d",
				$time, frames_out - base_frames, num_ports);
			test_errors++;
		end
		finish_test("single frame per port");

		// All ports at once with gaps on both sides
		gap_pct = 30;
		ready_pct = 60;
		for (int p = 0; p < num_ports; p++)
			frames_to_send[p] = 20;
		drain_all(20000);
		finish_test("random traffic");

		// Fabric stalled while port 0 pushes without gaps
		gap_pct = 0;
		ready_pct = 0;
		frames_to_send[0] = 1000;
		n = 0;
		while (rx_ready[0] && n < 2000) begin
			step_cycle();
			n++;
		end
		if (rx_ready[0]) begin
			$display("Timeout: rx_ready on port 0 never fell while the fabric was stalled");
			test_errors++;
		end
		frames_to_send[0] = 0;
		ready_pct = 70;
		drain_all(20000);
		finish_test("fabric stall");

		// Long frames push every ring past its wrap point
		len_min = 9;
		gap_pct = 20;
		ready_pct = 80;
		for (int p = 0; p < num_ports; p++) begin
			base_words[p] = words_sent[p];
			frames_to_send[p] = 14;
		end
		drain_all(20000);
		for (int p = 0; p < num_ports; p++) begin
			assert (words_sent[p] - base_words[p] > region_words) else begin
				$display("[ERROR] %0t: only %0d words on port %0d",
					$time, words_sent[p] - base_words[p], p);
				test_errors++;
			end
		end
		assert (model_empty()) else begin
			$display("[ERROR] %0t: expected frames left in the model", $time);
			test_errors++;
		end
		finish_test("ring wrap");

		$display("Tests run: %0d, failed: %0d, errors: %0d, frames out: %0d",
			tests_run, tests_failed, total_errors, frames_out);
		if (total_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== ingress_buffer.f ====
+incdir+test
hdl/ingress_buffer_cfg_pkg.sv
hdl/ingress_buffer_types_pkg.sv
hdl/sync_fifo.sv
hdl/ingress_port.sv
hdl/write_arbiter.sv
hdl/packet_ram.sv
hdl/frame_readout.sv
hdl/ingress_buffer.sv
test/tb_ingress_buffer.sv
